//--- verilog/bridge_pkg.sv
`default_nettype none

// Shared widths and codes for the UART host bridge
package bridge_pkg;

    // ========================================================================
    // Data widths
    // ========================================================================

    typedef logic [7:0] byte_t;              // One serial byte

    localparam int ub_word_bytes = 32;       // Bytes per unified-buffer word

    typedef logic [ub_word_bytes*8-1:0] ub_word_t;
    typedef logic [7:0]  ub_addr_t;          // UB word address
    typedef logic [31:0] instr_word_t;
    typedef logic [4:0]  instr_addr_t;       // 32 instruction slots
    typedef logic [15:0] len_t;              // Transfer length in bytes

    // ========================================================================
    // Host command codes
    // ========================================================================

    typedef enum logic [7:0] {
        cmd_write_ub    = 8'h01,
        cmd_write_instr = 8'h03,
        cmd_execute     = 8'h05,
        cmd_status      = 8'h06
    } cmd_e;

    // Reply bytes
    localparam byte_t resp_ack_ub = 8'hAA;   // Last UB word written
    localparam byte_t resp_error  = 8'hFF;   // Unknown command

endpackage

`default_nettype wire

//--- verilog/uart_byte_rx.sv
`timescale 1ns/1ps
`default_nettype none

// 8N1 receiver, one strobe per byte at mid stop bit
module uart_byte_rx #(
    parameter int clks_per_bit = 8
) (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic              uart_rx,
    output bridge_pkg::byte_t      rx_data,
    output logic                   rx_valid,
    output logic                   rx_framing_error
);

    localparam int cnt_w = $clog2(clks_per_bit);

    typedef enum logic [1:0] {
        rx_idle,
        rx_start,
        rx_bits,
        rx_stop
    } rx_state_e;

    rx_state_e          state;
    logic [1:0]         sync;               // Two-flop synchronizer
    logic [cnt_w-1:0]   clk_cnt;
    logic [2:0]         bit_idx;
    bridge_pkg::byte_t  shift;

    wire line = sync[1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync             <= 2'b11;      // Line idles high
            state            <= rx_idle;
            clk_cnt          <= '0;
            bit_idx          <= '0;
            shift            <= '0;
            rx_data          <= '0;
            rx_valid         <= 1'b0;
            rx_framing_error <= 1'b0;
        end else begin
            sync     <= {sync[0], uart_rx};
            rx_valid <= 1'b0;               // Strobe by default off
            clk_cnt  <= clk_cnt + 1'b1;
            case (state)
                rx_idle: begin
                    clk_cnt <= '0;
                    if (!line) state <= rx_start;   // Falling edge seen
                end
                rx_start: begin
                    // Mid start bit, reject glitches
                    if (clk_cnt == cnt_w'(clks_per_bit/2 - 1)) begin
                        clk_cnt <= '0;
                        bit_idx <= '0;
                        state   <= line ? rx_idle : rx_bits;
                    end
                end
                rx_bits: begin
                    if (clk_cnt == cnt_w'(clks_per_bit - 1)) begin
                        clk_cnt <= '0;
                        shift   <= {line, shift[7:1]};   // LSB first
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) state <= rx_stop;
                    end
                end
                rx_stop: begin
                    if (clk_cnt == cnt_w'(clks_per_bit - 1)) begin
                        rx_valid         <= 1'b1;
                        rx_data          <= shift;
                        rx_framing_error <= !line;   // Stop bit must be high
                        state            <= rx_idle;
                    end
                end
                default: state <= rx_idle;
            endcase
        end
    end

    // Engine takes a byte only on a single-cycle strobe
    a_rx_valid_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        rx_valid |=> !rx_valid);

endmodule

`default_nettype wire

//--- verilog/cmd_engine.sv
`timescale 1ns/1ps
`default_nettype none

// Host frame parser; drives UB and instruction writes, start pulse and replies
module cmd_engine (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire bridge_pkg::byte_t   rx_data,
    input  wire logic                rx_valid,
    input  wire logic                rx_framing_error,
    input  wire logic                sys_busy,
    input  wire logic                sys_done,
    input  wire logic                vpu_busy,
    input  wire logic                vpu_done,
    input  wire logic                ub_busy,
    input  wire logic                ub_done,
    output logic                     ub_wr_en,
    output bridge_pkg::ub_addr_t     ub_wr_addr,
    output bridge_pkg::ub_word_t     ub_wr_data,
    output logic                     instr_wr_en,
    output bridge_pkg::instr_addr_t  instr_wr_addr,
    output bridge_pkg::instr_word_t  instr_wr_data,
    output logic                     start_execution,
    output logic                     resp_push,
    output bridge_pkg::byte_t        resp_data
);

    typedef enum logic [2:0] {
        st_idle,
        st_addr_hi,
        st_addr_lo,
        st_len_hi,
        st_len_lo,
        st_ub_data,
        st_instr_data
    } state_e;

    state_e                  state;
    bridge_pkg::cmd_e        cmd;          // Write command in progress
    bridge_pkg::len_t        len_left;     // Data bytes still to come
    logic [4:0]              lane;         // Byte lane in word, or instr byte count
    bridge_pkg::ub_word_t    pack_buf;     // Partial UB word
    bridge_pkg::ub_word_t    pack_next;
    logic [23:0]             instr_shift;  // First three instruction bytes

    wire byte_ok   = rx_valid && !rx_framing_error;   // Bad frames are dropped
    wire word_full = (lane == 5'(bridge_pkg::ub_word_bytes - 1));
    wire last_byte = (len_left == 16'd1);

    // Current byte dropped into its lane
    always_comb begin
        pack_next = pack_buf;
        pack_next[{lane, 3'b000} +: 8] = rx_data;
    end

    // ========================================================================
    // Frame FSM
    // ========================================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state           <= st_idle;
            cmd             <= bridge_pkg::cmd_write_ub;
            len_left        <= '0;
            lane            <= '0;
            pack_buf        <= '0;
            instr_shift     <= '0;
            ub_wr_en        <= 1'b0;
            ub_wr_addr      <= '0;
            ub_wr_data      <= '0;
            instr_wr_en     <= 1'b0;
            instr_wr_addr   <= '0;
            instr_wr_data   <= '0;
            start_execution <= 1'b0;
            resp_push       <= 1'b0;
            resp_data       <= '0;
        end else begin
            // Pulses last one cycle
            ub_wr_en        <= 1'b0;
            instr_wr_en     <= 1'b0;
            start_execution <= 1'b0;
            resp_push       <= 1'b0;
            if (ub_wr_en) ub_wr_addr <= ub_wr_addr + 1'b1;   // Next word
            if (byte_ok) begin
                case (state)
                    st_idle: begin
                        case (rx_data)
                            bridge_pkg::cmd_write_ub,
                            bridge_pkg::cmd_write_instr: begin
                                cmd   <= bridge_pkg::cmd_e'(rx_data);
                                state <= st_addr_hi;
                            end
                            bridge_pkg::cmd_execute: start_execution <= 1'b1;
                            bridge_pkg::cmd_status: begin
                                resp_push <= 1'b1;
                                resp_data <= {2'b00, ub_done, ub_busy,
                                              vpu_done, vpu_busy, sys_done, sys_busy};
                            end
                            default: begin
                                resp_push <= 1'b1;
                                resp_data <= bridge_pkg::resp_error;
                            end
                        endcase
                    end
                    st_addr_hi: state <= st_addr_lo;   // High byte unused
                    st_addr_lo: begin
                        lane <= '0;
                        if (cmd == bridge_pkg::cmd_write_ub) begin
                            ub_wr_addr <= rx_data;
                            state      <= st_len_hi;
                        end else begin
                            instr_wr_addr <= rx_data[4:0];   // 32 slots
                            state         <= st_instr_data;
                        end
                    end
                    st_len_hi: begin
                        len_left[15:8] <= rx_data;
                        state          <= st_len_lo;
                    end
                    st_len_lo: begin
                        // Zero length counts as one byte
                        if ({len_left[15:8], rx_data} == 16'd0) len_left <= 16'd1;
                        else len_left <= {len_left[15:8], rx_data};
                        pack_buf <= '0;
                        state    <= st_ub_data;
                    end
                    st_ub_data: begin
                        len_left <= len_left - 1'b1;
                        if (word_full || last_byte) begin
                            ub_wr_en   <= 1'b1;
                            ub_wr_data <= pack_next;   // Unused lanes stay zero
                            pack_buf   <= '0;
                            lane       <= '0;
                        end else begin
                            pack_buf <= pack_next;
                            lane     <= lane + 1'b1;
                        end
                        if (last_byte) begin
                            resp_push <= 1'b1;
                            resp_data <= bridge_pkg::resp_ack_ub;
                            state     <= st_idle;
                        end
                    end
                    st_instr_data: begin
                        instr_shift <= {instr_shift[15:0], rx_data};
                        lane        <= lane + 1'b1;
                        if (lane == 5'd3) begin
                            instr_wr_en   <= 1'b1;
                            instr_wr_data <= {instr_shift, rx_data};   // First byte on top
                            state         <= st_idle;
                        end
                    end
                    default: state <= st_idle;
                endcase
            end
        end
    end

    // Only one buffer written per cycle
    a_one_write: assert property (@(posedge clk) disable iff (!rst_n)
        !(ub_wr_en && instr_wr_en));

endmodule

`default_nettype wire

//--- verilog/resp_fifo.sv
`timescale 1ns/1ps
`default_nettype none

// 4-deep reply queue in front of the transmitter
module resp_fifo (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire logic                resp_push,
    input  wire bridge_pkg::byte_t   resp_data,
    input  wire logic                tx_ready,
    output bridge_pkg::byte_t        tx_data,
    output logic                     tx_valid
);

    localparam int depth = 4;

    bridge_pkg::byte_t  mem [depth];
    logic [1:0]         wr_ptr;
    logic [1:0]         rd_ptr;
    logic [2:0]         count;       // 0 to depth

    wire full   = (count == 3'(depth));
    wire do_wr  = resp_push && !full;   // Overflow is lost
    wire do_rd  = tx_valid && tx_ready;

    assign tx_valid = (count != 3'd0);
    assign tx_data  = mem[rd_ptr];      // Head of queue

    // Storage
    always_ff @(posedge clk) begin
        if (do_wr) mem[wr_ptr] <= resp_data;
    end

    // Pointers wrap on their own at depth 4
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) wr_ptr <= wr_ptr + 1'b1;
            if (do_rd) rd_ptr <= rd_ptr + 1'b1;
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // Both or neither
            endcase
        end
    end

    // Engine must never outrun the serial line
    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        resp_push |-> !full);

endmodule

`default_nettype wire

//--- verilog/uart_byte_tx.sv
`timescale 1ns/1ps
`default_nettype none

// 8N1 transmitter, takes one byte per valid/ready handshake
module uart_byte_tx #(
    parameter int clks_per_bit = 8
) (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire bridge_pkg::byte_t   tx_data,
    input  wire logic                tx_valid,
    output logic                     tx_ready,
    output logic                     uart_tx
);

    localparam int cnt_w = $clog2(clks_per_bit);

    logic               busy;
    logic [cnt_w-1:0]   clk_cnt;
    logic [3:0]         bit_idx;     // Bit periods finished after start
    bridge_pkg::byte_t  shift;       // Refills with ones, so stop bit follows

    assign tx_ready = !busy;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy    <= 1'b0;
            clk_cnt <= '0;
            bit_idx <= '0;
            shift   <= '1;
            uart_tx <= 1'b1;             // Idle high
        end else if (!busy) begin
            if (tx_valid) begin
                busy    <= 1'b1;
                uart_tx <= 1'b0;         // Start bit
                shift   <= tx_data;
                clk_cnt <= '0;
                bit_idx <= '0;
            end
        end else begin
            clk_cnt <= clk_cnt + 1'b1;
            if (clk_cnt == cnt_w'(clks_per_bit - 1)) begin
                clk_cnt <= '0;
                if (bit_idx == 4'd9) begin
                    busy <= 1'b0;        // Stop bit done
                end else begin
                    uart_tx <= shift[0]; // Data LSB first, then stop
                    shift   <= {1'b1, shift[7:1]};
                    bit_idx <= bit_idx + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/uart_host_bridge.sv
`timescale 1ns/1ps
`default_nettype none

// UART host bridge top: rx -> engine -> reply queue -> tx
module uart_host_bridge #(
    parameter int clks_per_bit = 8
) (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire logic                uart_rx,
    input  wire logic                sys_busy,
    input  wire logic                sys_done,
    input  wire logic                vpu_busy,
    input  wire logic                vpu_done,
    input  wire logic                ub_busy,
    input  wire logic                ub_done,
    output logic                     uart_tx,
    output logic                     ub_wr_en,
    output bridge_pkg::ub_addr_t     ub_wr_addr,
    output bridge_pkg::ub_word_t     ub_wr_data,
    output logic                     instr_wr_en,
    output bridge_pkg::instr_addr_t  instr_wr_addr,
    output bridge_pkg::instr_word_t  instr_wr_data,
    output logic                     start_execution
);

    // ========================================================================
    // Internal byte paths
    // ========================================================================

    bridge_pkg::byte_t  rx_data;
    logic               rx_valid;
    logic               rx_framing_error;
    logic               resp_push;
    bridge_pkg::byte_t  resp_data;
    bridge_pkg::byte_t  tx_data;
    logic               tx_valid;
    logic               tx_ready;

    uart_byte_rx #(.clks_per_bit(clks_per_bit)) i_rx (
        .clk, .rst_n, .uart_rx,
        .rx_data, .rx_valid, .rx_framing_error
    );

    cmd_engine i_engine (
        .clk, .rst_n,
        .rx_data, .rx_valid, .rx_framing_error,
        .sys_busy, .sys_done, .vpu_busy, .vpu_done, .ub_busy, .ub_done,
        .ub_wr_en, .ub_wr_addr, .ub_wr_data,
        .instr_wr_en, .instr_wr_addr, .instr_wr_data,
        .start_execution,
        .resp_push, .resp_data
    );

    resp_fifo i_resp_fifo (
        .clk, .rst_n,
        .resp_push, .resp_data,
        .tx_ready, .tx_data, .tx_valid
    );

    uart_byte_tx #(.clks_per_bit(clks_per_bit)) i_tx (
        .clk, .rst_n,
        .tx_data, .tx_valid, .tx_ready,
        .uart_tx
    );

endmodule

`default_nettype wire

//--- dv/tb_uart_host_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module tb_uart_host_bridge;

    localparam int clks_per_bit = 8;
    localparam int max_records  = 64;

    logic clk = 1'b0;
    logic rst_n;
    logic uart_rx;
    logic sys_busy, sys_done, vpu_busy, vpu_done, ub_busy, ub_done;
    logic                     uart_tx;
    logic                     ub_wr_en;
    bridge_pkg::ub_addr_t     ub_wr_addr;
    bridge_pkg::ub_word_t     ub_wr_data;
    logic                     instr_wr_en;
    bridge_pkg::instr_addr_t  instr_wr_addr;
    bridge_pkg::instr_word_t  instr_wr_data;
    logic                     start_execution;

    logic [271:0]  records [max_records];    // data, aux, kind
    logic [7:0]    exp_reply_q [$];
    logic [7:0]    exp_ub_addr_q [$];
    logic [255:0]  exp_ub_data_q [$];
    logic [4:0]    exp_instr_addr_q [$];
    logic [31:0]   exp_instr_data_q [$];
    int            exp_start_cnt = 0;
    int            value_errors  = 0;
    int            event_errors  = 0;
    int            cycles        = 0;
    int            cycle_limit   = 2000;     // Raised once the records are read
    integer        seed          = 34791;    // Idle gaps between host bytes

    uart_host_bridge #(.clks_per_bit(clks_per_bit)) i_dut (
        .clk, .rst_n, .uart_rx,
        .sys_busy, .sys_done, .vpu_busy, .vpu_done, .ub_busy, .ub_done,
        .uart_tx, .ub_wr_en, .ub_wr_addr, .ub_wr_data,
        .instr_wr_en, .instr_wr_addr, .instr_wr_data, .start_execution
    );

    always #20 clk = ~clk;

    // ========================================================================
    // Host side stimulus
    // ========================================================================

    // One bit period between drive points 2 ns after an edge
    task automatic drive_bit(input logic val);
        uart_rx = val;
        repeat (clks_per_bit) @(posedge clk);
        #2;
    endtask

    task automatic send_byte(input logic [7:0] b, input logic good_stop);
        int i;
        int gap;
        drive_bit(1'b0);                    // Start bit
        for (i = 0; i < 8; i++) begin
            drive_bit(b[i]);                // LSB first
        end
        drive_bit(good_stop);
        uart_rx = 1'b1;
        gap = $random(seed) & 15;
        if (!good_stop) gap = gap + 2 * clks_per_bit;   // Receiver resyncs after bad stop
        repeat (gap) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic set_status(input logic [7:0] bits);
        sys_busy = bits[0];
        sys_done = bits[1];
        vpu_busy = bits[2];
        vpu_done = bits[3];
        ub_busy  = bits[4];
        ub_done  = bits[5];
    endtask

    // Queues expected events per kind in file order
    task automatic load_expectations();
        int idx;
        int sent_bytes;
        sent_bytes = 0;
        for (idx = 0; idx < max_records && records[idx][7:0] != 8'h00; idx++) begin
            case (records[idx][7:0])
                8'h02: sent_bytes += int'(records[idx][15:8]);
                8'h03: sent_bytes += 1;
                8'h04: exp_reply_q.push_back(records[idx][15:8]);
                8'h05: begin
                    exp_ub_addr_q.push_back(records[idx][15:8]);
                    exp_ub_data_q.push_back(records[idx][271:16]);
                end
                8'h06: begin
                    exp_instr_addr_q.push_back(records[idx][12:8]);
                    exp_instr_data_q.push_back(records[idx][47:16]);
                end
                8'h07: exp_start_cnt++;
                default: ;
            endcase
        end
        cycle_limit = sent_bytes * 10 * clks_per_bit * 3 + 2000;
    endtask

    function automatic logic all_seen();
        return exp_reply_q.size() == 0 && exp_ub_addr_q.size() == 0 &&
               exp_instr_addr_q.size() == 0 && exp_start_cnt == 0;
    endfunction

    initial begin : stimulus
        int idx;
        int n;
        rst_n   = 1'b0;
        uart_rx = 1'b1;                     // Line idle
        set_status(8'h00);
        for (idx = 0; idx < max_records; idx++) begin
            records[idx] = '0;              // Kind 00 ends the list
        end
        $readmemh("dv/bridge_input.txt", records);
        load_expectations();
        repeat (8) @(posedge clk);
        #2;
        rst_n = 1'b1;
        repeat (10) @(posedge clk);
        #2;
        for (idx = 0; idx < max_records && records[idx][7:0] != 8'h00; idx++) begin
            case (records[idx][7:0])
                8'h01: set_status(records[idx][15:8]);
                8'h02: begin
                    for (n = 0; n < int'(records[idx][15:8]); n++) begin
                        send_byte(records[idx][16 + 8*n +: 8], 1'b1);
                    end
                end
                8'h03: send_byte(records[idx][15:8], 1'b0);
                default: ;
            endcase
        end
        while (!all_seen()) @(posedge clk);
        repeat (300) @(posedge clk);        // Window for stray events
        $display("Summary: %0d value errors, %0d event errors", value_errors, event_errors);
        if (value_errors == 0 && event_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // ========================================================================
    // Monitors sampling on the falling edge
    // ========================================================================

    task automatic check_reply(input logic [7:0] got);
        if (exp_reply_q.size() == 0) begin
            $display("Unexpected reply byte 0x%02h on uart_tx at %0t ns", got, $time);
            event_errors++;
        end else begin
            if (got !== exp_reply_q[0]) begin
                $display("FAIL %0t ns: reply 0x%02h, expected 0x%02h", $time, got,
                         exp_reply_q[0]);
                value_errors++;
            end
            void'(exp_reply_q.pop_front());
        end
    endtask

    initial begin : serial_monitor
        logic [7:0] got;
        int i;
        forever begin
            @(negedge clk);
            if (rst_n === 1'b1 && uart_tx === 1'b0) begin
                repeat (clks_per_bit / 2) @(negedge clk);   // Mid start bit
                for (i = 0; i < 8; i++) begin
                    repeat (clks_per_bit) @(negedge clk);
                    got[i] = uart_tx;
                end
                repeat (clks_per_bit) @(negedge clk);
                if (uart_tx !== 1'b1) begin
                    $display("Reply frame ending at %0t ns has a low stop bit", $time);
                    event_errors++;
                end
                check_reply(got);
            end
        end
    end

    always @(negedge clk) begin
        if (rst_n && ub_wr_en) begin
            if (exp_ub_addr_q.size() == 0) begin
                $display("Unexpected unified-buffer write at %0t ns", $time);
                event_errors++;
            end else begin
                if (ub_wr_addr !== exp_ub_addr_q[0] || ub_wr_data !== exp_ub_data_q[0]) begin
                    $display("FAIL %0t ns: UB write 0x%02h = 0x%064h, expected 0x%02h = 0x%064h",
                             $time, ub_wr_addr, ub_wr_data,
                             exp_ub_addr_q[0], exp_ub_data_q[0]);
                    value_errors++;
                end
                void'(exp_ub_addr_q.pop_front());
                void'(exp_ub_data_q.pop_front());
            end
        end
    end

    always @(negedge clk) begin
        if (rst_n && instr_wr_en) begin
            if (exp_instr_addr_q.size() == 0) begin
                $display("Unexpected instruction write at %0t ns", $time);
                event_errors++;
            end else begin
                if (instr_wr_addr !== exp_instr_addr_q[0] ||
                    instr_wr_data !== exp_instr_data_q[0]) begin
                    $display("FAIL %0t ns: instr slot %0d = 0x%08h, expected slot %0d = 0x%08h",
                             $time, instr_wr_addr, instr_wr_data,
                             exp_instr_addr_q[0], exp_instr_data_q[0]);
                    value_errors++;
                end
                void'(exp_instr_addr_q.pop_front());
                void'(exp_instr_data_q.pop_front());
            end
        end
    end

    always @(negedge clk) begin
        if (rst_n && start_execution) begin
            if (exp_start_cnt == 0) begin
                $display("Extra start_execution pulse at %0t ns", $time);
                event_errors++;
            end else begin
                exp_start_cnt--;
            end
        end
    end

    // Run limit from the number of host bytes
    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("Timeout after %0d cycles", cycles);
            $display("Never seen: %0d replies, %0d UB writes, %0d instr writes, %0d starts",
                     exp_reply_q.size(), exp_ub_addr_q.size(),
                     exp_instr_addr_q.size(), exp_start_cnt);
            $display("Summary: %0d value errors, %0d event errors", value_errors, event_errors);
            $display("*** FAILED ***");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- dv/bridge_input.txt
// Record in hex: data (256 bits, lane 0 lowest), aux byte, kind byte
// Kinds: 01 status=aux, 02 send aux bytes of data, 03 send aux with low stop, 04 reply aux, 05 UB write at aux, 06 instr write slot aux, 07 start
// UB write, 40 bytes at address 5
28000500010502
2f2e2d2c2b2a292827262524232221201f1e1d1c1b1a191817161514131211102002
37363534333231300802
2f2e2d2c2b2a292827262524232221201f1e1d1c1b1a191817161514131211100505
37363534333231300605
aa04
// Instruction write to slot 9
785634120900030702
123456780906
// Execute
050102
0007
// Status read, two settings
1501
060102
1504
2a01
060102
2a04
// Unknown command
7e0102
ff04
// UB write with a bad-stop byte in the middle
b2a104002000010702
5a03
d4c30202
d4c3b2a12005
aa04

//--- files.f
verilog/bridge_pkg.sv
verilog/uart_byte_rx.sv
verilog/cmd_engine.sv
verilog/resp_fifo.sv
verilog/uart_byte_tx.sv
verilog/uart_host_bridge.sv
dv/tb_uart_host_bridge.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the UART host bridge testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_uart_host_bridge \
    -f files.f \
    -o sim_uart_host_bridge

out=$(./obj_dir/sim_uart_host_bridge)
echo "$out"

if echo "$out" | grep -qF '*** PASSED ***'; then
    exit 0
fi
exit 1
